/* Bender.yml */
package:
  name: dual_z80_bus

sources:
  - hw/dual_z80_bus_pkg.sv
  - hw/main_cpu_decoder.sv
  - hw/sub_cpu_decoder.sv
  - hw/irq_control.sv
  - hw/video_bus_bridge.sv
  - hw/dual_z80_bus.sv
  - target: simulation
    files:
      - verif/dual_z80_bus_props.sv
      - verif/dual_z80_bus_tb.sv

/* dual_z80_bus.f */
hw/dual_z80_bus_pkg.sv
hw/main_cpu_decoder.sv
hw/sub_cpu_decoder.sv
hw/irq_control.sv
hw/video_bus_bridge.sv
hw/dual_z80_bus.sv
verif/dual_z80_bus_props.sv
verif/dual_z80_bus_tb.sv

/* hw/dual_z80_bus.sv */
// Top of the dual Z80 bus glue, CPU cores and ROMs stay outside
// Wait lines are not handled here, each CPU's strobes are active low
`timescale 1ns/10ps

module dual_z80_bus (
    input  logic                                clk,
    input  logic                                RESETn,
    // Main CPU bus
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpua_addr,
    input  logic                                cpua_mreq_n,
    input  logic                                cpua_rd_n,
    input  logic                                cpua_wr_n,
    input  logic                                cpua_iorq_n,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_dout,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_din,
    output logic                                cpua_ae,
    output logic                                cpua_int_n,
    output logic                                cpua_nmi_n,
    // Sub CPU bus
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpub_addr,
    input  logic                                cpub_mreq_n,
    input  logic                                cpub_rd_n,
    input  logic                                cpub_wr_n,
    input  logic                                cpub_iorq_n,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] cpub_dout,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] cpub_din,
    output logic                                cpub_be,
    output logic                                cpub_int_n,
    output logic                                cpub_nmi_n,
    // External ROMs
    output dual_z80_bus_pkg::mem_region_e       rom_a_region,
    output dual_z80_bus_pkg::mem_region_e       rom_b_region,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] rom_a_data,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] rom_b_data,
    // Inputs and switches
    input  logic [15:0]                         player,
    input  logic [15:0]                         dsw,
    input  logic                                snd_busy,
    // Video side
    input  logic                                vbl,
    input  logic                                a_b,
    input  logic                                wba,
    input  logic                                wbb,
    input  logic                                rla,
    input  logic                                rlb,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] v_in,
    output logic [dual_z80_bus_pkg::VA_W-1:0]   va,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] v_out
);
    import dual_z80_bus_pkg::*;

    logic [DATA_W-1:0] cpua_bus_dout;  // Registered main write data
    logic [DATA_W-1:0] vin_a;
    logic [DATA_W-1:0] vin_b;
    logic              cpua_mbox_rd;
    logic              cpua_mbox_wr;
    logic              cpub_mbox_rd;
    logic              cpub_mbox_wr;

    main_cpu_decoder u_main_dec (
        .clk          (clk),
        .RESETn       (RESETn),
        .cpua_addr    (cpua_addr),
        .cpua_mreq_n  (cpua_mreq_n),
        .cpua_rd_n    (cpua_rd_n),
        .cpua_wr_n    (cpua_wr_n),
        .cpua_dout    (cpua_dout),
        .rom_a_data   (rom_a_data),
        .player       (player),
        .dsw          (dsw),
        .snd_busy     (snd_busy),
        .vin_a        (vin_a),
        .rom_a_region (rom_a_region),
        .cpua_din     (cpua_din),
        .cpua_bus_dout(cpua_bus_dout),
        .cpua_ae      (cpua_ae),
        .cpua_mbox_rd (cpua_mbox_rd),
        .cpua_mbox_wr (cpua_mbox_wr)
    );

    sub_cpu_decoder u_sub_dec (
        .clk         (clk),
        .RESETn      (RESETn),
        .cpub_addr   (cpub_addr),
        .cpub_mreq_n (cpub_mreq_n),
        .cpub_rd_n   (cpub_rd_n),
        .cpub_wr_n   (cpub_wr_n),
        .rom_b_data  (rom_b_data),
        .vin_b       (vin_b),
        .rom_b_region(rom_b_region),
        .cpub_din    (cpub_din),
        .cpub_be     (cpub_be),
        .cpub_mbox_rd(cpub_mbox_rd),
        .cpub_mbox_wr(cpub_mbox_wr)
    );

    // Interrupts and mailbox NMIs
    irq_control u_irq (
        .clk         (clk),
        .RESETn      (RESETn),
        .vbl         (vbl),
        .cpua_iorq_n (cpua_iorq_n),
        .cpub_iorq_n (cpub_iorq_n),
        .cpua_mbox_rd(cpua_mbox_rd),
        .cpua_mbox_wr(cpua_mbox_wr),
        .cpub_mbox_rd(cpub_mbox_rd),
        .cpub_mbox_wr(cpub_mbox_wr),
        .cpua_int_n  (cpua_int_n),
        .cpub_int_n  (cpub_int_n),
        .cpua_nmi_n  (cpua_nmi_n),
        .cpub_nmi_n  (cpub_nmi_n)
    );

    video_bus_bridge u_bridge (
        .clk          (clk),
        .RESETn       (RESETn),
        .a_b          (a_b),
        .cpua_addr    (cpua_addr),
        .cpub_addr    (cpub_addr),
        .wba          (wba),
        .wbb          (wbb),
        .rla          (rla),
        .rlb          (rlb),
        .cpua_bus_dout(cpua_bus_dout),
        .cpub_dout    (cpub_dout),
        .v_in         (v_in),
        .va           (va),
        .v_out        (v_out),
        .vin_a        (vin_a),
        .vin_b        (vin_b)
    );

endmodule

/* hw/dual_z80_bus_pkg.sv */
// Widths, idle bus value and address encodings shared by the dual Z80 glue
// Widths are fixed by the Z80 and the board and are not meant to be changed
package dual_z80_bus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int ADDR_W = 16;  // Z80 address bus
    localparam int DATA_W = 8;   // Z80 data bus
    localparam int VA_W   = 12;  // Shared video address, 4K window

    // Pulled-up data bus, seen when nothing drives a read
    localparam logic [DATA_W-1:0] BUS_IDLE = '1;

    // ------------------------------
    // Memory map, top two address bits
    // ------------------------------
    typedef enum logic [1:0] {
        REGION_ROM0 = 2'b00,  // 0000..3FFF
        REGION_ROM1 = 2'b01,  // 4000..7FFF
        REGION_ROM2 = 2'b10,  // 8000..BFFF
        REGION_HIGH = 2'b11   // C000..FFFF, I/O block and video window
    } mem_region_e;

    // ------------------------------
    // Main CPU I/O block C000..C7FF
    // ------------------------------
    // One port per 256 byte page, picked by A10..A8
    typedef enum logic [2:0] {
        PORT_COIN    = 3'd0,  // C000 coin and sound status
        PORT_P1      = 3'd1,  // C100 player 1
        PORT_P2      = 3'd2,  // C200 player 2
        PORT_P1P2    = 3'd3,  // C300 not fitted on the board
        PORT_MCODE   = 3'd4,  // C400 write only
        PORT_DIP1    = 3'd5,  // C500
        PORT_DIP2    = 3'd6,  // C600
        PORT_MAILBOX = 3'd7   // C700 cross NMI mailbox
    } io_port_e;

endpackage

/* hw/irq_control.sv */
// VBL interrupts and cross CPU NMI mailbox, all sampled on clk
// Inputs are taken as synchronous to clk, a clear wins over a set on the same edge
`timescale 1ns/10ps

module irq_control (
    input  logic clk,
    input  logic RESETn,
    input  logic vbl,
    input  logic cpua_iorq_n,
    input  logic cpub_iorq_n,
    input  logic cpua_mbox_rd,
    input  logic cpua_mbox_wr,
    input  logic cpub_mbox_rd,
    input  logic cpub_mbox_wr,
    output logic cpua_int_n,
    output logic cpub_int_n,
    output logic cpua_nmi_n,
    output logic cpub_nmi_n
);
    // Latch slots in the pending vector
    localparam int INT_A = 0;
    localparam int INT_B = 1;
    localparam int NMI_A = 2;
    localparam int NMI_B = 3;

    logic       vbl_q;       // Previous samples for edge detection
    logic       a_rd_q;
    logic       b_rd_q;
    logic       vbl_rise;
    logic       a_rd_end;
    logic       b_rd_end;
    logic [3:0] set_v;
    logic [3:0] clr_v;
    logic [3:0] pend;        // High while the request is outstanding

    // ------------------------------
    // Edge detect
    // ------------------------------
    assign vbl_rise = vbl & ~vbl_q;
    assign a_rd_end = a_rd_q & ~cpua_mbox_rd;  // Main read of C700 just finished
    assign b_rd_end = b_rd_q & ~cpub_mbox_rd;  // Sub read of C000 block just finished

    // ------------------------------
    // Set and clear terms
    // ------------------------------
    assign set_v[INT_A] = vbl_rise;        // Both CPUs get the frame interrupt
    assign set_v[INT_B] = vbl_rise;
    assign set_v[NMI_A] = b_rd_end;        // Sub pokes main
    assign set_v[NMI_B] = a_rd_end;        // Main pokes sub
    assign clr_v[INT_A] = ~cpua_iorq_n;    // Interrupt ack cycle
    assign clr_v[INT_B] = ~cpub_iorq_n;
    assign clr_v[NMI_A] = cpua_mbox_wr;    // Main writes its mailbox to ack
    assign clr_v[NMI_B] = cpub_mbox_wr;

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            vbl_q  <= 1'b0;
            a_rd_q <= 1'b0;
            b_rd_q <= 1'b0;
            pend   <= '0;
        end else begin
            vbl_q  <= vbl;
            a_rd_q <= cpua_mbox_rd;
            b_rd_q <= cpub_mbox_rd;
            pend   <= (pend | set_v) & ~clr_v;  // Clear has priority
        end
    end

    // Active low toward the CPUs
    assign cpua_int_n = ~pend[INT_A];
    assign cpub_int_n = ~pend[INT_B];
    assign cpua_nmi_n = ~pend[NMI_A];
    assign cpub_nmi_n = ~pend[NMI_B];

endmodule

/* hw/main_cpu_decoder.sv */
// Main CPU decode with a registered read mux, din lags the address by one clock
// I/O ports are selected on MREQ_n alone, reads of write-only ports return idle
`timescale 1ns/10ps

module main_cpu_decoder (
    input  logic                                clk,
    input  logic                                RESETn,
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpua_addr,
    input  logic                                cpua_mreq_n,
    input  logic                                cpua_rd_n,
    input  logic                                cpua_wr_n,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_dout,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] rom_a_data,
    input  logic [15:0]                         player,
    input  logic [15:0]                         dsw,
    input  logic                                snd_busy,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] vin_a,
    output dual_z80_bus_pkg::mem_region_e       rom_a_region,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_din,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_bus_dout,
    output logic                                cpua_ae,
    output logic                                cpua_mbox_rd,
    output logic                                cpua_mbox_wr
);
    import dual_z80_bus_pkg::*;

    logic              high_sel;  // C000..FFFF
    logic              io_blk;    // A13..A11 zero, the C000..C7FF block
    logic              io_sel;
    logic              mbox_sel;
    logic              vid_rd;    // Read of the shared video window
    io_port_e          io_port;
    logic [DATA_W-1:0] rd_byte;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign rom_a_region = mem_region_e'(cpua_addr[15:14]);
    assign high_sel     = (rom_a_region == REGION_HIGH);
    assign io_blk       = (cpua_addr[13:11] == 3'b000);
    assign io_port      = io_port_e'(cpua_addr[10:8]);

    assign io_sel   = ~cpua_mreq_n & high_sel & io_blk;
    assign mbox_sel = io_sel & (io_port == PORT_MAILBOX);
    assign cpua_ae  = ~cpua_mreq_n & high_sel & ~io_blk;   // C800..FFFF
    assign vid_rd   = ~cpua_rd_n & high_sel & ~io_blk;     // No MREQ_n term, as on the board

    assign cpua_mbox_rd = mbox_sel & ~cpua_rd_n;  // Triggers sub CPU NMI on its end
    assign cpua_mbox_wr = mbox_sel & ~cpua_wr_n;  // Acks own NMI

    // ------------------------------
    // Read byte select
    // ------------------------------
    always_comb begin
        rd_byte = BUS_IDLE;
        if (!cpua_mreq_n && !high_sel) begin
            rd_byte = rom_a_data;
        end else if (io_sel) begin
            case (io_port)
                PORT_COIN: rd_byte = {2'b11, snd_busy, 1'b1,
                                      player[1], player[9], 1'b1, player[0]};
                // Both players share one input word on this board
                PORT_P1, PORT_P2: rd_byte = {1'b1, player[3], player[2], player[4],
                                             player[11], player[10], player[12], player[13]};
                PORT_DIP1: rd_byte = dsw[7:0];
                PORT_DIP2: rd_byte = dsw[15:8];
                default:   rd_byte = BUS_IDLE;  // P1P2, MCODE and mailbox
            endcase
        end else if (vid_rd) begin
            rd_byte = vin_a;
        end
    end

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            cpua_din      <= BUS_IDLE;
            cpua_bus_dout <= BUS_IDLE;
        end else begin
            cpua_din <= rd_byte;
            // Write data toward the video bus, only for the high region
            if (!cpua_mreq_n && high_sel) begin
                cpua_bus_dout <= cpua_dout;
            end else begin
                cpua_bus_dout <= BUS_IDLE;
            end
        end
    end

endmodule

/* hw/sub_cpu_decoder.sv */
// Sub CPU decode and registered read mux, din lags the address by one clock
// ROM data is returned for any address below C000, MREQ_n is not checked there
`timescale 1ns/10ps

module sub_cpu_decoder (
    input  logic                                clk,
    input  logic                                RESETn,
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpub_addr,
    input  logic                                cpub_mreq_n,
    input  logic                                cpub_rd_n,
    input  logic                                cpub_wr_n,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] rom_b_data,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] vin_b,
    output dual_z80_bus_pkg::mem_region_e       rom_b_region,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] cpub_din,
    output logic                                cpub_be,
    output logic                                cpub_mbox_rd,
    output logic                                cpub_mbox_wr
);
    import dual_z80_bus_pkg::*;

    logic              high_sel;  // C000..FFFF
    logic              mbox_blk;  // C000..C7FF, the whole block is the mailbox
    logic              mbox_sel;
    logic              vid_rd;
    logic [DATA_W-1:0] rd_byte;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign rom_b_region = mem_region_e'(cpub_addr[15:14]);
    assign high_sel     = (rom_b_region == REGION_HIGH);
    assign mbox_blk     = (cpub_addr[13:11] == 3'b000);

    assign mbox_sel = ~cpub_mreq_n & high_sel & mbox_blk;
    assign cpub_be  = ~cpub_mreq_n & high_sel & ~mbox_blk;  // C800..FFFF
    assign vid_rd   = ~cpub_rd_n & high_sel & ~mbox_blk;

    assign cpub_mbox_rd = mbox_sel & ~cpub_rd_n;  // Triggers main CPU NMI on its end
    assign cpub_mbox_wr = mbox_sel & ~cpub_wr_n;  // Acks own NMI

    // First match wins
    always_comb begin
        if (!high_sel) begin
            rd_byte = rom_b_data;
        end else if (cpub_mbox_rd) begin
            rd_byte = BUS_IDLE;  // Mailbox has no data, only the strobe
        end else if (vid_rd) begin
            rd_byte = vin_b;
        end else begin
            rd_byte = BUS_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            cpub_din <= BUS_IDLE;
        end else begin
            cpub_din <= rd_byte;
        end
    end

endmodule

/* hw/video_bus_bridge.sv */
// Shared video bus between the two CPUs, a_b picks whose address drives va
// Bus arbitration itself (a_b, wba, wbb, rla, rlb) comes from the video timing outside
`timescale 1ns/10ps

module video_bus_bridge (
    input  logic                                clk,
    input  logic                                RESETn,
    input  logic                                a_b,
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpua_addr,
    input  logic [dual_z80_bus_pkg::ADDR_W-1:0] cpub_addr,
    input  logic                                wba,
    input  logic                                wbb,
    input  logic                                rla,
    input  logic                                rlb,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] cpua_bus_dout,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] cpub_dout,
    input  logic [dual_z80_bus_pkg::DATA_W-1:0] v_in,
    output logic [dual_z80_bus_pkg::VA_W-1:0]   va,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] v_out,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] vin_a,
    output logic [dual_z80_bus_pkg::DATA_W-1:0] vin_b
);
    import dual_z80_bus_pkg::*;

    // ------------------------------
    // Address mux
    // ------------------------------
    // High selects the sub CPU
    assign va = a_b ? cpub_addr[VA_W-1:0] : cpua_addr[VA_W-1:0];

    // ------------------------------
    // Write data select
    // ------------------------------
    // Main CPU has priority when both write buffers are enabled
    always_comb begin
        if (!wba) begin
            v_out = cpua_bus_dout;  // Already registered in the main decoder
        end else if (!wbb) begin
            v_out = cpub_dout;
        end else begin
            v_out = BUS_IDLE;
        end
    end

    // ------------------------------
    // Read latches
    // ------------------------------
    // Clocked stand-ins for the board's transparent latches
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            vin_a <= '0;
            vin_b <= '0;
        end else begin
            if (rla) begin
                vin_a <= v_in;
            end
            if (rlb) begin
                vin_b <= v_in;
            end
        end
    end

endmodule

/* verif/dual_z80_bus_props.sv */
// Concurrent checks on the VBL interrupt and mailbox NMI latches
// Bound into irq_control, sampled on the same clock as the design
`timescale 1ns/10ps

module dual_z80_bus_props (
    input logic clk,
    input logic RESETn,
    input logic vbl,
    input logic cpua_mbox_wr,
    input logic cpub_mbox_wr,
    input logic cpua_int_n,
    input logic cpub_int_n,
    input logic cpua_nmi_n,
    input logic cpub_nmi_n
);

    // Synchronous reset leaves every request line high
    reset_idle: assert property (@(posedge clk)
        !RESETn |=> (cpua_int_n && cpub_int_n && cpua_nmi_n && cpub_nmi_n))
        else $error("Interrupt or NMI line low after a reset cycle");

    // Mailbox write acks the NMI of the writing CPU
    nmi_a_ack: assert property (@(posedge clk) disable iff (!RESETn)
        cpua_mbox_wr |=> cpua_nmi_n)
        else $error("Main NMI still low after its mailbox write");
    nmi_b_ack: assert property (@(posedge clk) disable iff (!RESETn)
        cpub_mbox_wr |=> cpub_nmi_n)
        else $error("Sub NMI still low after its mailbox write");

    // int_n falls one edge after the edge that saw vbl rise
    int_a_src: assert property (@(posedge clk) disable iff (!RESETn)
        $fell(cpua_int_n) |-> ($past(vbl) && !$past(vbl, 2)))
        else $error("Main int_n fell without a vbl rise");
    int_b_src: assert property (@(posedge clk) disable iff (!RESETn)
        $fell(cpub_int_n) |-> ($past(vbl) && !$past(vbl, 2)))
        else $error("Sub int_n fell without a vbl rise");

endmodule

bind irq_control dual_z80_bus_props u_props (.*);

/* verif/dual_z80_bus_tb.sv */
// Table driven testbench for the dual Z80 bus glue, one table row per clock
// Rows are driven on the falling edge and checked on the next falling edge
`timescale 1ns/10ps

module dual_z80_bus_tb;
    import dual_z80_bus_pkg::*;

    // One table row, bus inputs then expected responses
    typedef struct packed {
        logic [15:0] a_addr;
        logic        a_mreq_n;
        logic        a_rd_n;
        logic        a_wr_n;
        logic        a_iorq_n;
        logic [7:0]  a_dout;
        logic [7:0]  rom_a;
        logic [15:0] b_addr;
        logic        b_mreq_n;
        logic        b_rd_n;
        logic        b_wr_n;
        logic        b_iorq_n;
        logic [7:0]  b_dout;
        logic [7:0]  rom_b;
        logic        vbl;
        logic        a_b;
        logic        wba;
        logic        wbb;
        logic        rla;
        logic        rlb;
        logic [7:0]  v_in;
        logic [7:0]  exp_a_din;
        logic [7:0]  exp_b_din;
        logic [7:0]  exp_v_out;
        logic [11:0] exp_va;
        logic [3:0]  exp_irq;  // int_a, int_b, nmi_a, nmi_b
    } step_t;

    logic        clk;
    logic        RESETn;
    logic [15:0] cpua_addr;
    logic        cpua_mreq_n;
    logic        cpua_rd_n;
    logic        cpua_wr_n;
    logic        cpua_iorq_n;
    logic [7:0]  cpua_dout;
    logic [7:0]  cpua_din;
    logic        cpua_ae;
    logic        cpua_int_n;
    logic        cpua_nmi_n;
    logic [15:0] cpub_addr;
    logic        cpub_mreq_n;
    logic        cpub_rd_n;
    logic        cpub_wr_n;
    logic        cpub_iorq_n;
    logic [7:0]  cpub_dout;
    logic [7:0]  cpub_din;
    logic        cpub_be;
    logic        cpub_int_n;
    logic        cpub_nmi_n;
    mem_region_e rom_a_region;
    mem_region_e rom_b_region;
    logic [7:0]  rom_a_data;
    logic [7:0]  rom_b_data;
    logic [15:0] player;
    logic [15:0] dsw;
    logic        snd_busy;
    logic        vbl;
    logic        a_b;
    logic        wba;
    logic        wbb;
    logic        rla;
    logic        rlb;
    logic [7:0]  v_in;
    logic [11:0] va;
    logic [7:0]  v_out;

    step_t       steps [0:63];
    string       names [0:63];
    step_t       cur;          // Row under construction
    logic [3:0]  e_irq;        // Expected interrupt levels while building
    logic [15:0] lfsr;
    int          n_steps;
    int          err_cnt;
    int          chk_cnt;
    int          cycles;

    dual_z80_bus u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 125 MHz
    end

    // ------------------------------
    // Random source
    // ------------------------------
    // 16 bit Galois LFSR, one step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] val;
        logic        bit_out;
        val = '0;
        for (int k = 0; k < n; k++) begin
            bit_out = lfsr[0];
            lfsr    = lfsr >> 1;
            if (bit_out) begin
                lfsr = lfsr ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1
            end
            val = {val[14:0], bit_out};
        end
        return val;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [15:0] v;
        v = take_bits(8);
        return v[7:0];
    endfunction

    // ------------------------------
    // Table construction
    // ------------------------------
    // Both CPUs parked high with no strobes, write buffers off
    task automatic idle_row();
        cur          = '0;
        cur.a_addr   = 16'hFFFF;
        cur.a_mreq_n = 1'b1;
        cur.a_rd_n   = 1'b1;
        cur.a_wr_n   = 1'b1;
        cur.a_iorq_n = 1'b1;
        cur.a_dout   = rand_byte();
        cur.rom_a    = rand_byte();
        cur.b_addr   = 16'hFFFF;
        cur.b_mreq_n = 1'b1;
        cur.b_rd_n   = 1'b1;
        cur.b_wr_n   = 1'b1;
        cur.b_iorq_n = 1'b1;
        cur.b_dout   = rand_byte();
        cur.rom_b    = rand_byte();
        cur.wba      = 1'b1;
        cur.wbb      = 1'b1;
        cur.v_in     = rand_byte();
    endtask

    task automatic main_read(input logic [15:0] addr);
        cur.a_addr   = addr;
        cur.a_mreq_n = 1'b0;
        cur.a_rd_n   = 1'b0;
    endtask

    task automatic sub_read(input logic [15:0] addr);
        cur.b_addr   = addr;
        cur.b_mreq_n = 1'b0;
        cur.b_rd_n   = 1'b0;
    endtask

    // va and v_out follow from the bridge rules, din is given by the caller
    task automatic push_row(input string name, input logic [7:0] exp_a, input logic [7:0] exp_b);
        logic [7:0] bus_a;  // Main write data as latched toward the video bus
        bus_a = (!cur.a_mreq_n && cur.a_addr[15:14] == 2'b11) ? cur.a_dout : 8'hFF;
        cur.exp_a_din = exp_a;
        cur.exp_b_din = exp_b;
        cur.exp_va    = cur.a_b ? cur.b_addr[11:0] : cur.a_addr[11:0];
        if (!cur.wba) begin
            cur.exp_v_out = bus_a;
        end else if (!cur.wbb) begin
            cur.exp_v_out = cur.b_dout;
        end else begin
            cur.exp_v_out = 8'hFF;
        end
        cur.exp_irq      = e_irq;
        steps[n_steps] = cur;
        names[n_steps] = name;
        n_steps++;
    endtask

    task automatic build_table();
        logic [15:0] rnd;
        logic [7:0]  p1_byte;
        logic [7:0]  lat;
        p1_byte = {1'b1, player[3], player[2], player[4],
                   player[11], player[10], player[12], player[13]};
        // ROM reads, both CPUs in the same region
        for (int r = 0; r < 3; r++) begin
            idle_row();
            rnd = take_bits(14);
            main_read({r[1:0], rnd[13:0]});
            rnd = take_bits(14);
            sub_read({r[1:0], rnd[13:0]});
            push_row($sformatf("rom_read_r%0d", r), cur.rom_a, cur.rom_b);
        end
        // Main I/O ports
        idle_row();
        main_read(16'hC000);
        push_row("io_coin", {2'b11, snd_busy, 1'b1, player[1], player[9], 1'b1, player[0]},
                 8'hFF);
        idle_row();
        main_read({8'hC1, rand_byte()});
        push_row("io_p1", p1_byte, 8'hFF);
        idle_row();
        main_read({8'hC2, rand_byte()});
        push_row("io_p2", p1_byte, 8'hFF);
        idle_row();
        main_read(16'hC500);
        push_row("io_dip1", dsw[7:0], 8'hFF);
        idle_row();
        main_read(16'hC600);
        push_row("io_dip2", dsw[15:8], 8'hFF);
        idle_row();
        main_read(16'hC300);
        push_row("io_p1p2", 8'hFF, 8'hFF);
        idle_row();
        main_read(16'hC400);   // Write only port
        push_row("io_unmapped", 8'hFF, 8'hFF);
        // ------------------------------
        // Video read latches
        // ------------------------------
        idle_row();
        cur.rla = 1'b1;
        lat     = cur.v_in;
        push_row("latch_a_load", 8'hFF, 8'hFF);
        for (int h = 0; h < 2; h++) begin
            idle_row();
            rnd = take_bits(12);
            main_read({4'hE, rnd[11:0]});
            push_row($sformatf("latch_a_read%0d", h), lat, 8'hFF);
        end
        idle_row();
        cur.rlb = 1'b1;
        lat     = cur.v_in;
        push_row("latch_b_load", 8'hFF, 8'hFF);
        for (int h = 0; h < 2; h++) begin
            idle_row();
            rnd = take_bits(12);
            sub_read({4'hF, rnd[11:0]});
            push_row($sformatf("latch_b_read%0d", h), 8'hFF, lat);
        end
        // Address mux and write data select
        idle_row();
        rnd        = take_bits(12);
        cur.b_addr = {4'hF, rnd[11:0]};
        cur.a_b    = 1'b1;
        push_row("va_sub", 8'hFF, 8'hFF);
        idle_row();
        rnd          = take_bits(12);
        cur.a_addr   = {4'hD, rnd[11:0]};
        cur.a_mreq_n = 1'b0;
        cur.a_wr_n   = 1'b0;
        cur.wba      = 1'b0;
        cur.wbb      = 1'b0;   // Main wins
        push_row("vout_main", 8'hFF, 8'hFF);
        idle_row();
        cur.wbb = 1'b0;
        push_row("vout_sub", 8'hFF, 8'hFF);
        idle_row();
        cur.wba = 1'b0;        // No main access, idle data
        push_row("vout_main_idle", 8'hFF, 8'hFF);
        // ------------------------------
        // Cross NMI mailbox
        // ------------------------------
        idle_row();
        sub_read(16'hC000);
        push_row("sub_mbox_rd", 8'hFF, 8'hFF);
        idle_row();
        e_irq = 4'b1101;       // nmi_a set once the read ends
        push_row("sub_mbox_end", 8'hFF, 8'hFF);
        idle_row();
        push_row("nmi_a_held", 8'hFF, 8'hFF);
        idle_row();
        cur.a_addr   = {8'hC7, rand_byte()};
        cur.a_mreq_n = 1'b0;
        cur.a_wr_n   = 1'b0;
        e_irq        = 4'b1111;
        push_row("main_mbox_wr", 8'hFF, 8'hFF);
        idle_row();
        main_read(16'hC700);
        push_row("main_mbox_rd", 8'hFF, 8'hFF);
        idle_row();
        e_irq = 4'b1110;
        push_row("main_mbox_end", 8'hFF, 8'hFF);
        idle_row();
        cur.b_addr   = 16'hC000;
        cur.b_mreq_n = 1'b0;
        cur.b_wr_n   = 1'b0;
        e_irq        = 4'b1111;
        push_row("sub_mbox_wr", 8'hFF, 8'hFF);
        // VBL interrupts
        idle_row();
        cur.vbl = 1'b1;
        e_irq   = 4'b0011;
        push_row("vbl_rise", 8'hFF, 8'hFF);
        idle_row();
        cur.vbl = 1'b1;        // Level alone must not retrigger
        push_row("vbl_high", 8'hFF, 8'hFF);
        idle_row();
        cur.a_iorq_n = 1'b0;
        e_irq        = 4'b1011;
        push_row("int_a_ack", 8'hFF, 8'hFF);
        idle_row();
        push_row("int_b_wait", 8'hFF, 8'hFF);
        idle_row();
        cur.b_iorq_n = 1'b0;
        e_irq        = 4'b1111;
        push_row("int_b_ack", 8'hFF, 8'hFF);
    endtask

    // ------------------------------
    // Drive and check
    // ------------------------------
    task automatic drive_step(input step_t s);
        cpua_addr   = s.a_addr;
        cpua_mreq_n = s.a_mreq_n;
        cpua_rd_n   = s.a_rd_n;
        cpua_wr_n   = s.a_wr_n;
        cpua_iorq_n = s.a_iorq_n;
        cpua_dout   = s.a_dout;
        rom_a_data  = s.rom_a;
        cpub_addr   = s.b_addr;
        cpub_mreq_n = s.b_mreq_n;
        cpub_rd_n   = s.b_rd_n;
        cpub_wr_n   = s.b_wr_n;
        cpub_iorq_n = s.b_iorq_n;
        cpub_dout   = s.b_dout;
        rom_b_data  = s.rom_b;
        vbl         = s.vbl;
        a_b         = s.a_b;
        wba         = s.wba;
        wbb         = s.wbb;
        rla         = s.rla;
        rlb         = s.rlb;
        v_in        = s.v_in;
    endtask

    task automatic check_val(input string name, input string sig,
                             input logic [15:0] exp, input logic [15:0] act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("ERR %s %s expected %h actual %h", name, sig, exp, act);
        end
    endtask

    task automatic check_step(input int i);
        step_t s;
        logic  exp_ae;   // Memory cycle in C800..FFFF
        logic  exp_be;
        s      = steps[i];
        exp_ae = !s.a_mreq_n && (s.a_addr >= 16'hC800);
        exp_be = !s.b_mreq_n && (s.b_addr >= 16'hC800);
        check_val(names[i], "cpua_din", s.exp_a_din, cpua_din);
        check_val(names[i], "cpub_din", s.exp_b_din, cpub_din);
        check_val(names[i], "cpua_ae", exp_ae, cpua_ae);
        check_val(names[i], "cpub_be", exp_be, cpub_be);
        check_val(names[i], "rom_a_region", s.a_addr[15:14], rom_a_region);
        check_val(names[i], "rom_b_region", s.b_addr[15:14], rom_b_region);
        check_val(names[i], "va", s.exp_va, va);
        check_val(names[i], "v_out", s.exp_v_out, v_out);
        check_val(names[i], "int_nmi", s.exp_irq,
                  {cpua_int_n, cpub_int_n, cpua_nmi_n, cpub_nmi_n});
    endtask

    initial begin
        logic [15:0] rnd;
        lfsr    = 16'd91;
        n_steps = 0;
        err_cnt = 0;
        chk_cnt = 0;
        e_irq   = 4'b1111;     // Nothing pending after reset
        player  = take_bits(16);
        dsw     = take_bits(16);
        rnd     = take_bits(1);
        snd_busy = rnd[0];
        RESETn  = 1'b0;
        idle_row();
        drive_step(cur);
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        RESETn = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_step(i - 1);  // Previous row has seen its edge
            end
            drive_step(steps[i]);
        end
        @(negedge clk);
        check_step(n_steps - 1);
        $display("Rows %0d, checks %0d, errors %0d", n_steps, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        cycles = 0;
        while (cycles <= n_steps * 4 + 50) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the table run did not complete", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule
